// File: rtl/scaler_pkg.sv
package scaler_pkg;

    localparam int PIX_W   = 8;
    localparam int MAX_DIM = 32;
    localparam int DIM_W   = 6;
    localparam int ADDR_W  = 10;
    localparam int FRAC_W  = 16;
    localparam int POS_W   = DIM_W + FRAC_W;
    localparam int WT_W    = 34;  // 17b x 17b product

    typedef struct packed {
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic vsync;
        logic de;
        rgb_t pix;
    } video_t;

    typedef struct packed {
        logic [DIM_W-1:0]  src_w;
        logic [DIM_W-1:0]  src_h;
        logic [DIM_W-1:0]  dst_w;
        logic [DIM_W-1:0]  dst_h;
        logic [FRAC_W-1:0] x_ratio;
        logic [FRAC_W-1:0] y_ratio;
    } scale_cfg_t;

    typedef struct packed {
        logic              vsync;
        logic              de;
        logic [DIM_W-1:0]  x_int;
        logic [DIM_W-1:0]  y_int;
        logic [FRAC_W-1:0] x_frac;
        logic [FRAC_W-1:0] y_frac;
    } coord_t;

    typedef struct packed {
        rgb_t p00;
        rgb_t p01;
        rgb_t p10;
        rgb_t p11;
    } quad_t;

    typedef struct packed {
        logic [WT_W-1:0] w00;
        logic [WT_W-1:0] w01;
        logic [WT_W-1:0] w10;
        logic [WT_W-1:0] w11;
    } weight_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_Y_LOAD,
        S_X_SWEEP,
        S_Y_INC
    } sched_state_e;

    // row-major, one row per MAX_DIM entries
    function automatic logic [ADDR_W-1:0] store_addr(
        input logic [DIM_W-1:0] x,
        input logic [DIM_W-1:0] y
    );
        store_addr = ADDR_W'(y) * ADDR_W'(MAX_DIM) + ADDR_W'(x);
    endfunction

endpackage

// File: rtl/src_writer.sv
`timescale 1ns/1ps

module src_writer
    import scaler_pkg::*;
(
    input  logic              clk_in2,
    input  logic              rst_n,
    input  scale_cfg_t        cfg,
    input  video_t            src,
    output logic              wr_en,
    output logic [ADDR_W-1:0] wr_addr,
    output rgb_t              wr_pix,
    output logic [DIM_W-1:0]  rows_done,
    output logic              frame_start
);

    logic             vs_d;
    logic             valid_d;
    logic             pix_valid;
    logic             row_end;
    logic [DIM_W-1:0] col_cnt;
    logic [DIM_W-1:0] row_cnt;

    assign pix_valid   = src.vsync & src.de;
    assign row_end     = src.vsync & valid_d & ~pix_valid;  // falling de
    assign frame_start = src.vsync & ~vs_d;
    assign rows_done   = row_cnt;

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            vs_d    <= 1'b0;
            valid_d <= 1'b0;
            col_cnt <= '0;
            row_cnt <= '0;
            wr_en   <= 1'b0;
        end
        else
        begin
            vs_d    <= src.vsync;
            valid_d <= pix_valid;
            col_cnt <= pix_valid ? col_cnt + 1'b1 : '0;
            if (!src.vsync)
                row_cnt <= '0;
            else if (row_end)
                row_cnt <= row_cnt + 1'b1;
            // drop anything outside the configured frame
            wr_en <= pix_valid && (col_cnt < cfg.src_w) && (row_cnt < cfg.src_h);
        end
    end

    always_ff @(posedge clk_in2)
    begin
        wr_addr <= store_addr(col_cnt, row_cnt);
        wr_pix  <= src.pix;
    end

endmodule

// File: rtl/frame_store.sv
`timescale 1ns/1ps

module frame_store
    import scaler_pkg::*;
(
    input  logic              clk_in2,
    input  scale_cfg_t        cfg,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  rgb_t              wr_pix,
    input  logic [DIM_W-1:0]  rd_x,
    input  logic [DIM_W-1:0]  rd_y,
    output quad_t             quad
);

    rgb_t             mem [MAX_DIM*MAX_DIM];
    logic [DIM_W-1:0] rd_x1;
    logic [DIM_W-1:0] rd_y1;

    // right / bottom neighbour, held at the last column and row
    assign rd_x1 = (rd_x + 1'b1 >= cfg.src_w) ? cfg.src_w - 1'b1 : rd_x + 1'b1;
    assign rd_y1 = (rd_y + 1'b1 >= cfg.src_h) ? cfg.src_h - 1'b1 : rd_y + 1'b1;

    always_ff @(posedge clk_in2)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_pix;
    end

    // ------------------------------
    // 2x2 read, one cycle

    always_ff @(posedge clk_in2)
    begin
        quad.p00 <= mem[store_addr(rd_x,  rd_y)];
        quad.p01 <= mem[store_addr(rd_x1, rd_y)];
        quad.p10 <= mem[store_addr(rd_x,  rd_y1)];
        quad.p11 <= mem[store_addr(rd_x1, rd_y1)];
    end

endmodule

// File: rtl/output_scheduler.sv
`timescale 1ns/1ps

module output_scheduler
    import scaler_pkg::*;
(
    input  logic             clk_in2,
    input  logic             rst_n,
    input  scale_cfg_t       cfg,
    input  logic [DIM_W-1:0] rows_done,
    input  logic             frame_start,
    output coord_t           coord
);

    sched_state_e     state;
    logic [POS_W-1:0] x_acc;
    logic [POS_W-1:0] y_acc;
    logic [DIM_W-1:0] x_cnt;
    logic [DIM_W-1:0] y_cnt;
    logic [DIM_W-1:0] y_int;
    logic [DIM_W:0]   rows_need;
    logic             rows_ready;
    logic             last_col;
    logic             last_row;
    logic             vs_q;
    logic             de_q;
    logic [POS_W-1:0] x_pos_q;
    logic [POS_W-1:0] y_pos_q;

    assign y_int    = y_acc[POS_W-1:FRAC_W];
    assign last_col = (x_cnt == cfg.dst_w - 1'b1);
    assign last_row = (y_cnt == cfg.dst_h - 1'b1);

    // rows y_int and y_int+1, only y_int on the bottom source row
    assign rows_need  = (y_int + 1'b1 >= cfg.src_h) ? (DIM_W+1)'(cfg.src_h)
                                                    : (DIM_W+1)'(y_int) + 2'd2;
    assign rows_ready = ((DIM_W+1)'(rows_done) >= rows_need);

    // ------------------------------
    // raster FSM

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
            y_acc <= '0;
            y_cnt <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (frame_start)
                    begin
                        y_acc <= '0;
                        y_cnt <= '0;
                        state <= S_Y_LOAD;
                    end
                end
                S_Y_LOAD:
                begin
                    if (rows_ready)
                        state <= S_X_SWEEP;
                end
                S_X_SWEEP:
                begin
                    if (last_col)
                        state <= S_Y_INC;
                end
                S_Y_INC:
                begin
                    y_acc <= y_acc + cfg.y_ratio;
                    y_cnt <= y_cnt + 1'b1;
                    state <= last_row ? S_IDLE : S_Y_LOAD;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            x_acc <= '0;
            x_cnt <= '0;
        end
        else if (state == S_X_SWEEP)
        begin
            x_acc <= x_acc + cfg.x_ratio;
            x_cnt <= x_cnt + 1'b1;
        end
        else
        begin
            x_acc <= '0;
            x_cnt <= '0;
        end
    end

    // ------------------------------
    // sample register

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            vs_q <= 1'b0;
            de_q <= 1'b0;
        end
        else
        begin
            de_q <= (state == S_X_SWEEP);
            if (state == S_X_SWEEP && x_cnt == '0 && y_cnt == '0)
                vs_q <= 1'b1;  // first sample
            else if (state == S_Y_INC && last_row)
                vs_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_in2)
    begin
        x_pos_q <= x_acc;
        y_pos_q <= y_acc;
    end

    assign coord = '{vsync:  vs_q,
                     de:     de_q,
                     x_int:  x_pos_q[POS_W-1:FRAC_W],
                     y_int:  y_pos_q[POS_W-1:FRAC_W],
                     x_frac: x_pos_q[FRAC_W-1:0],
                     y_frac: y_pos_q[FRAC_W-1:0]};

endmodule

// File: rtl/weight_gen.sv
`timescale 1ns/1ps

module weight_gen
    import scaler_pkg::*;
(
    input  logic             clk_in2,
    input  logic             rst_n,
    input  coord_t           coord,
    output logic [DIM_W-1:0] rd_x,
    output logic [DIM_W-1:0] rd_y,
    output weight_t          weights,
    output logic             sync_vs,
    output logic             sync_de
);

    logic [FRAC_W:0] fx;
    logic [FRAC_W:0] fy;
    logic [FRAC_W:0] inv_fx;
    logic [FRAC_W:0] inv_fy;

    assign fx     = {1'b0, coord.x_frac};
    assign fy     = {1'b0, coord.y_frac};
    assign inv_fx = {1'b1, {FRAC_W{1'b0}}} - fx;  // 1.0 - frac
    assign inv_fy = {1'b1, {FRAC_W{1'b0}}} - fy;

    always_ff @(posedge clk_in2)
    begin
        rd_x        <= coord.x_int;
        rd_y        <= coord.y_int;
        weights.w00 <= inv_fx * inv_fy;
        weights.w01 <= fx * inv_fy;
        weights.w10 <= inv_fx * fy;
        weights.w11 <= fx * fy;
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            sync_vs <= 1'b0;
            sync_de <= 1'b0;
        end
        else
        begin
            sync_vs <= coord.vsync;
            sync_de <= coord.de;
        end
    end

endmodule

// File: rtl/blend_unit.sv
`timescale 1ns/1ps

module blend_unit
    import scaler_pkg::*;
(
    input  logic    clk_in2,
    input  logic    rst_n,
    input  quad_t   quad,
    input  weight_t weights,
    input  logic    sync_vs,
    input  logic    sync_de,
    output video_t  post
);

    weight_t                 w_q;
    logic [5:0]              vs_pipe;  // align + 5 math stages
    logic [5:0]              de_pipe;
    logic [WT_W+PIX_W-1:0]   prod_q [3][4];
    logic [WT_W+PIX_W:0]     hsum_q [3][2];
    logic [WT_W+PIX_W+1:0]   vsum_q [3];
    logic [PIX_W+3:0]        rnd_q  [3];
    logic [PIX_W-1:0]        sat_q  [3];

    function automatic logic [PIX_W-1:0] chan(input rgb_t p, input int c);
        case (c)
            0:       chan = p.r;
            1:       chan = p.g;
            default: chan = p.b;
        endcase
    endfunction

    always_ff @(posedge clk_in2)
    begin
        w_q <= weights;  // meets quad from the store
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            vs_pipe <= '0;
            de_pipe <= '0;
        end
        else
        begin
            vs_pipe <= {vs_pipe[4:0], sync_vs};
            de_pipe <= {de_pipe[4:0], sync_de};
        end
    end

    // ------------------------------
    // per channel math

    for (genvar c = 0; c < 3; c++)
    begin : g_chan
        always_ff @(posedge clk_in2)
        begin
            prod_q[c][0] <= w_q.w00 * chan(quad.p00, c);
            prod_q[c][1] <= w_q.w01 * chan(quad.p01, c);
            prod_q[c][2] <= w_q.w10 * chan(quad.p10, c);
            prod_q[c][3] <= w_q.w11 * chan(quad.p11, c);
            hsum_q[c][0] <= prod_q[c][0] + prod_q[c][1];  // top row
            hsum_q[c][1] <= prod_q[c][2] + prod_q[c][3];  // bottom row
            vsum_q[c]    <= hsum_q[c][0] + hsum_q[c][1];
            rnd_q[c]     <= vsum_q[c][WT_W+PIX_W+1:2*FRAC_W] + vsum_q[c][2*FRAC_W-1];
            sat_q[c]     <= (|rnd_q[c][PIX_W+3:PIX_W]) ? {PIX_W{1'b1}} : rnd_q[c][PIX_W-1:0];
        end
    end

    assign post = '{vsync: vs_pipe[5],
                    de:    de_pipe[5],
                    pix:   '{r: sat_q[0], g: sat_q[1], b: sat_q[2]}};

endmodule

// File: rtl/bilinear_scaler.sv
`timescale 1ns/1ps

module bilinear_scaler
    import scaler_pkg::*;
(
    input  logic       clk_in2,
    input  logic       rst_n,
    input  scale_cfg_t cfg,
    input  video_t     src,
    output video_t     post
);

    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    rgb_t              wr_pix;
    logic [DIM_W-1:0]  rows_done;
    logic              frame_start;
    coord_t            coord;
    logic [DIM_W-1:0]  rd_x;
    logic [DIM_W-1:0]  rd_y;
    weight_t           weights;
    logic              sync_vs;
    logic              sync_de;
    quad_t             quad;

    src_writer u_src_writer (
        .clk_in2     (clk_in2),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .src         (src),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_pix      (wr_pix),
        .rows_done   (rows_done),
        .frame_start (frame_start)
    );

    frame_store u_frame_store (
        .clk_in2 (clk_in2),
        .cfg     (cfg),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_pix  (wr_pix),
        .rd_x    (rd_x),
        .rd_y    (rd_y),
        .quad    (quad)
    );

    output_scheduler u_output_scheduler (
        .clk_in2     (clk_in2),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .rows_done   (rows_done),
        .frame_start (frame_start),
        .coord       (coord)
    );

    weight_gen u_weight_gen (
        .clk_in2 (clk_in2),
        .rst_n   (rst_n),
        .coord   (coord),
        .rd_x    (rd_x),
        .rd_y    (rd_y),
        .weights (weights),
        .sync_vs (sync_vs),
        .sync_de (sync_de)
    );

    blend_unit u_blend_unit (
        .clk_in2 (clk_in2),
        .rst_n   (rst_n),
        .quad    (quad),
        .weights (weights),
        .sync_vs (sync_vs),
        .sync_de (sync_de),
        .post    (post)
    );

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen
(
    output logic clk_in2,
    output logic rst_n
);

    initial
    begin
        clk_in2 = 1'b0;
        forever #10 clk_in2 = ~clk_in2;  // 20 ns period
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk_in2);
        @(negedge clk_in2);
        rst_n = 1'b1;
    end

endmodule

// File: bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_pix   = 0;
int err_count = 0;
int err_bit   = 0;

task automatic check_pix(input string what, input rgb_t got, input rgb_t exp);
    if (got !== exp)
    begin
        err_pix++;
        $display("ERROR %0d ns: %s got %02h %02h %02h, expected %02h %02h %02h",
                 $time, what, got.r, got.g, got.b, exp.r, exp.g, exp.b);
    end
endtask

task automatic check_count(input string what, input int got, input int exp);
    if (got !== exp)
    begin
        err_count++;
        $display("ERROR %0d ns: %s got %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
        err_bit++;
        $display("ERROR %0d ns: %s got %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

// File: bench/tb_bilinear_scaler.sv
`timescale 1ns/1ps

module tb_bilinear_scaler
    import scaler_pkg::*;
;

    // source plus destination pixels of every frame sent
    localparam int TOTAL_PIX   = (16 + 64) + (16 + 49) + (15 + 91) + 2 * (16 + 30);
    localparam int TIMEOUT_CYC = 20 * TOTAL_PIX + 2000;

    logic       clk_in2;
    logic       rst_n;
    scale_cfg_t cfg;
    video_t     src;
    video_t     post;

    rgb_t img [MAX_DIM][MAX_DIM];  // [row][col]
    rgb_t pix_q [$];
    int   frame_cnt_q [$];
    int   sw;
    int   sh;
    int   dw;
    int   dh;
    int   xr;
    int   yr;
    int   seed;
    int   de_cnt;
    int   cycle_cnt;
    int   total_err;

    `include "tb_checks.svh"

    clk_gen u_clk_gen (
        .clk_in2 (clk_in2),
        .rst_n   (rst_n)
    );

    bilinear_scaler dut (
        .clk_in2 (clk_in2),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .src     (src),
        .post    (post)
    );

    // ------------------------------
    // reference model

    function automatic logic [PIX_W-1:0] mix(input longint w00, w01, w10, w11,
                                             input int v00, v01, v10, v11);
        longint acc;
        longint q;
        acc = w00 * v00 + w01 * v01 + w10 * v10 + w11 * v11;
        q   = (acc >>> 32) + ((acc >>> 31) & 1);  // round at bit 31
        mix = (q > 255) ? 8'hFF : 8'(q);
    endfunction

    function automatic rgb_t model_pix(input int ox, input int oy);
        int     px;
        int     py;
        int     x0;
        int     y0;
        int     x1;
        int     y1;
        longint fx;
        longint fy;
        longint w00;
        longint w01;
        longint w10;
        longint w11;
        rgb_t   res;
        px  = ox * xr;
        py  = oy * yr;
        x0  = px >> 16;
        y0  = py >> 16;
        x1  = (x0 + 1 >= sw) ? sw - 1 : x0 + 1;  // edge copy
        y1  = (y0 + 1 >= sh) ? sh - 1 : y0 + 1;
        fx  = px & 32'hFFFF;
        fy  = py & 32'hFFFF;
        w00 = (65536 - fx) * (65536 - fy);
        w01 = fx * (65536 - fy);
        w10 = (65536 - fx) * fy;
        w11 = fx * fy;
        res.r = mix(w00, w01, w10, w11,
                    img[y0][x0].r, img[y0][x1].r, img[y1][x0].r, img[y1][x1].r);
        res.g = mix(w00, w01, w10, w11,
                    img[y0][x0].g, img[y0][x1].g, img[y1][x0].g, img[y1][x1].g);
        res.b = mix(w00, w01, w10, w11,
                    img[y0][x0].b, img[y0][x1].b, img[y1][x0].b, img[y1][x1].b);
        return res;
    endfunction

    // ------------------------------
    // stimulus and monitor

    task automatic watch_output();
        logic vs_prev;
        logic de_prev;
        vs_prev = 1'b0;
        de_prev = 1'b0;
        forever
        begin
            @(negedge clk_in2);
            if (post.vsync && !vs_prev)
                check_bit("post.de at vsync rise", post.de, 1'b1);
            if (!post.vsync && vs_prev)
            begin
                check_bit("post.de before vsync fall", de_prev, 1'b1);
                frame_cnt_q.push_back(de_cnt);
                de_cnt = 0;
            end
            if (post.vsync !== 1'b1)
                check_bit("post.de outside vsync", post.de, 1'b0);
            if (post.de === 1'b1)
            begin
                pix_q.push_back(post.pix);
                de_cnt++;
            end
            vs_prev = post.vsync;
            de_prev = post.de;
        end
    endtask

    task automatic send_frame();
        int x;
        int y;
        @(negedge clk_in2);
        src.vsync = 1'b1;
        repeat (4) @(negedge clk_in2);
        for (y = 0; y < sh; y++)
        begin
            for (x = 0; x < sw; x++)
            begin
                src.de  = 1'b1;
                src.pix = img[y][x];
                @(negedge clk_in2);
            end
            src.de  = 1'b0;
            src.pix = '0;
            repeat (4) @(negedge clk_in2);  // row gap
        end
        // vsync held until the scaled frame has left
        while (post.vsync !== 1'b1)
            @(negedge clk_in2);
        while (post.vsync === 1'b1)
            @(negedge clk_in2);
        src.vsync = 1'b0;
        repeat (4) @(negedge clk_in2);
    endtask

    task automatic run_scale(input string name, input int s_w, input int s_h,
                             input int d_w, input int d_h);
        int i;
        int j;
        sw = s_w;
        sh = s_h;
        dw = d_w;
        dh = d_h;
        xr = (sw * 65536) / dw;
        yr = (sh * 65536) / dh;
        cfg.src_w   = DIM_W'(sw);
        cfg.src_h   = DIM_W'(sh);
        cfg.dst_w   = DIM_W'(dw);
        cfg.dst_h   = DIM_W'(dh);
        cfg.x_ratio = FRAC_W'(xr);
        cfg.y_ratio = FRAC_W'(yr);
        pix_q.delete();
        send_frame();
        check_count({name, " pixel count"}, pix_q.size(), dw * dh);
        for (j = 0; j < dh; j++)
            for (i = 0; i < dw; i++)
                if (j * dw + i < pix_q.size())
                    check_pix($sformatf("%s at (%0d,%0d)", name, i, j),
                              pix_q[j * dw + i], model_pix(i, j));
    endtask

    task automatic fill_random(input int w, input int h);
        int x;
        int y;
        for (y = 0; y < h; y++)
            for (x = 0; x < w; x++)
                img[y][x] = rgb_t'($random(seed));
    endtask

    // ------------------------------
    // directed tests

    task automatic idle_after_reset();
        repeat (20)
        begin
            @(negedge clk_in2);
            check_bit("post.de after reset", post.de, 1'b0);
            check_bit("post.vsync after reset", post.vsync, 1'b0);
        end
    endtask

    task automatic scale_ramp();
        int x;
        int y;
        for (y = 0; y < 4; y++)
            for (x = 0; x < 4; x++)
                img[y][x] = '{r: 8'(x * 60), g: 8'(y * 60), b: 8'(x * 20 + y * 40)};
        run_scale("ramp 4x4 to 8x8", 4, 4, 8, 8);
    endtask

    task automatic scale_edge();
        int x;
        int y;
        for (y = 0; y < 4; y++)
            for (x = 0; x < 4; x++)
                img[y][x] = '{r: 8'(x * 16), g: 8'(y * 16), b: 8'h40};
        for (y = 0; y < 4; y++)
            img[y][3] = '{r: 8'hE0, g: 8'(y * 30 + 20), b: 8'h10};  // last column
        for (x = 0; x < 4; x++)
            img[3][x] = '{r: 8'(x * 30 + 5), g: 8'hD0, b: 8'hA0};  // last row
        img[3][3] = '{r: 8'hFF, g: 8'h01, b: 8'hFF};
        run_scale("edge 4x4 to 7x7", 4, 4, 7, 7);
    endtask

    task automatic scale_random();
        fill_random(5, 3);
        run_scale("random 5x3 to 13x7", 5, 3, 13, 7);
    endtask

    task automatic two_frame_framing();
        frame_cnt_q.delete();
        fill_random(4, 4);
        run_scale("frame A 4x4 to 6x5", 4, 4, 6, 5);
        fill_random(4, 4);
        run_scale("frame B 4x4 to 6x5", 4, 4, 6, 5);
        check_count("frames seen", frame_cnt_q.size(), 2);
        foreach (frame_cnt_q[k])
            check_count($sformatf("de count of frame %0d", k), frame_cnt_q[k], 30);
    endtask

    initial
    begin
        seed   = 72;
        de_cnt = 0;
        src    = '0;
        cfg    = '0;
        wait (rst_n === 1'b1);
        @(negedge clk_in2);
        fork
            watch_output();
        join_none
        idle_after_reset();
        scale_ramp();
        scale_edge();
        scale_random();
        two_frame_framing();
        total_err = err_pix + err_count + err_bit;
        $display("errors: pixel %0d, count %0d, bit %0d", err_pix, err_count, err_bit);
        if (total_err == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC)
        begin
            @(posedge clk_in2);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Something failed");
        $finish;
    end

endmodule

// File: bilinear_scaler.f
+incdir+bench
rtl/scaler_pkg.sv
rtl/src_writer.sv
rtl/frame_store.sv
rtl/output_scheduler.sv
rtl/weight_gen.sv
rtl/blend_unit.sv
rtl/bilinear_scaler.sv
bench/clk_gen.sv
bench/tb_bilinear_scaler.sv

// File: Bender.yml
package:
  name: bilinear_scaler

sources:
  - rtl/scaler_pkg.sv
  - rtl/src_writer.sv
  - rtl/frame_store.sv
  - rtl/output_scheduler.sv
  - rtl/weight_gen.sv
  - rtl/blend_unit.sv
  - rtl/bilinear_scaler.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/clk_gen.sv
      - bench/tb_bilinear_scaler.sv
